//--- logic/dma_pkg.sv
// DMA channel word definitions
package dma_pkg;

  //**********************************************************
  // channel word format
  //**********************************************************
  localparam int DMA_DATA_W = 64;
  localparam int DMA_CTRL_W = 8;

  // same layout in both directions of the channel
  typedef struct packed {
    logic [DMA_DATA_W-1:0] data;
    logic [DMA_CTRL_W-1:0] ctrl;
  } dma_word_t;

  //**********************************************************
  // control bit positions
  //**********************************************************
  localparam int CTRL_FIRST_ACK  = 0;
  localparam int CTRL_END        = 3; // last payload word of a transfer
  localparam int CTRL_REQ        = 4; // request header or acknowledge
  localparam int CTRL_SECOND_ACK = 5;

  //**********************************************************
  // header and acknowledge fields
  //**********************************************************
  localparam int TAG_LSB   = 32; // tag of the first header up to bit 63
  localparam int LEN_W     = 16; // length in words in the first header
  localparam int BYTES_LSB = 48; // byte count of the second header up to bit 63

  // tag bits 7..4 go back in the same data bits
  localparam int ACK_TAG_LSB = 4;
  localparam int ACK_LEN_W   = 24; // length field of the second ack

  // request as captured from the two header words
  typedef struct packed {
    logic [DMA_DATA_W-TAG_LSB-1:0]   tag;
    logic [LEN_W-1:0]                len_words;
    logic [DMA_DATA_W-BYTES_LSB-1:0] byte_cnt;
  } up_req_t;

endpackage

//--- logic/axis_pkg.sv
// AXI-stream beat definitions
package axis_pkg;

  //**********************************************************
  // beat format
  //**********************************************************
  localparam int AXIS_DATA_W = 64;
  localparam int KEEP_W      = AXIS_DATA_W / 8; // one bit per byte lane

  // tvalid and tready travel beside the beat
  typedef struct packed {
    logic [AXIS_DATA_W-1:0] tdata;
    logic [KEEP_W-1:0]      tkeep;
    logic                   tlast;
  } axis_beat_t;

endpackage

//--- logic/stream_slice.sv
// Single-entry stream register slice
`timescale 1ns/10ps

module stream_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,

  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  logic full;
  logic in_fire;

  // empty, or the held entry leaves this cycle
  assign in_ready  = !full || out_ready;
  assign in_fire   = in_valid && in_ready;
  assign out_valid = full;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      full <= 1'b0;
    else if (in_fire)
      full <= 1'b1;
    else if (out_ready)
      full <= 1'b0; // drained with nothing behind it
  end

  // held stable until the output handshake
  always_ff @(posedge clk)
  begin
    if (in_fire)
      out_data <= in_data;
  end

endmodule

//--- logic/up_req_decode.sv
// Upstream request decoder
`timescale 1ns/10ps

module up_req_decode (
  input  logic                 clk,
  input  logic                 rst_n,

  input  dma_pkg::dma_word_t   tohost,
  input  logic                 tohost_valid,
  output logic                 tohost_almost_full,

  output axis_pkg::axis_beat_t beat,
  output logic                 beat_valid,
  input  logic                 beat_ready,

  output dma_pkg::up_req_t     req,
  output logic                 req_done,
  input  logic                 ack_idle
);

  import dma_pkg::*;
  import axis_pkg::*;

  localparam int REM_W = $clog2(KEEP_W); // byte count bits inside one word

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HDR2,
    ST_DATA,
    ST_ACK_WAIT
  } state_t;

  state_t            state;
  up_req_t           req_q;
  logic              in_fire;
  logic              hdr_fire;
  logic              end_word;
  logic [KEEP_W-1:0] keep_last;

  //**********************************************************
  // input handshake
  //**********************************************************
  always_comb
  begin
    case (state)
      ST_DATA:     tohost_almost_full = !beat_ready; // follow the slice
      ST_ACK_WAIT: tohost_almost_full = 1'b1;
      default:     tohost_almost_full = 1'b0;         // headers never stall
    endcase
  end

  assign in_fire  = tohost_valid && !tohost_almost_full;
  assign end_word = tohost.ctrl[CTRL_END];
  assign hdr_fire = in_fire && tohost.ctrl[CTRL_REQ] && !end_word;

  //**********************************************************
  // transfer FSM
  //**********************************************************
  // reset lands in the ack wait state, so the host sees a stall during reset
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_ACK_WAIT;
    else
    begin
      case (state)
        ST_IDLE:
          if (hdr_fire)
            state <= ST_HDR2;
        ST_HDR2:
          if (hdr_fire)
            state <= ST_DATA;
        ST_DATA:
          if (in_fire && end_word)
            state <= ST_ACK_WAIT;
        ST_ACK_WAIT:
          if (ack_idle)
            state <= ST_IDLE; // both acks gone
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // header fields
  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && hdr_fire)
    begin
      req_q.tag       <= tohost.data[DMA_DATA_W-1:TAG_LSB];
      req_q.len_words <= tohost.data[LEN_W-1:0];
    end
    if (state == ST_HDR2 && hdr_fire)
      req_q.byte_cnt <= tohost.data[DMA_DATA_W-1:BYTES_LSB];
  end

  //**********************************************************
  // payload beats
  //**********************************************************
  // partial last word keeps only the lowest lanes
  always_comb
  begin
    keep_last = '1;
    if (req_q.byte_cnt[REM_W-1:0] != '0)
      keep_last = (KEEP_W'(1) << req_q.byte_cnt[REM_W-1:0]) - KEEP_W'(1);
  end

  always_comb
  begin
    beat.tdata = tohost.data;
    beat.tlast = end_word;
    beat.tkeep = end_word ? keep_last : '1;
  end

  assign beat_valid = (state == ST_DATA) && tohost_valid;

  assign req      = req_q;
  assign req_done = (state == ST_DATA) && in_fire && end_word; // final beat pushed

endmodule

//--- logic/up_ack_gen.sv
// Upstream acknowledge generator
`timescale 1ns/10ps

module up_ack_gen (
  input  logic               clk,
  input  logic               rst_n,

  input  dma_pkg::up_req_t   req,
  input  logic               req_done,
  output logic               ack_idle,

  output dma_pkg::dma_word_t fromhost,
  output logic               fromhost_valid,
  input  logic               fromhost_accept
);

  import dma_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SECOND,
    ST_DRAIN
  } state_t;

  state_t            state;
  logic [LEN_W-1:0]  len_q;
  dma_word_t         ack_word;
  logic              ack_valid;
  logic              ack_ready;

  //**********************************************************
  // acknowledge words
  //**********************************************************
  // first word goes straight from req into the empty slice
  always_comb
  begin
    ack_word = '0;
    ack_word.ctrl[CTRL_REQ] = 1'b1;
    if (state == ST_IDLE)
    begin
      ack_word.ctrl[CTRL_FIRST_ACK]   = 1'b1;
      ack_word.data[ACK_TAG_LSB +: 4] = req.tag[ACK_TAG_LSB +: 4];
    end
    else
    begin
      ack_word.ctrl[CTRL_SECOND_ACK] = 1'b1;
      ack_word.data[ACK_LEN_W-1:0]   = ACK_LEN_W'(len_q); // zero-extended
    end
  end

  assign ack_valid = (state == ST_IDLE) ? req_done : (state == ST_SECOND);
  assign ack_idle  = (state == ST_IDLE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
    begin
      case (state)
        ST_IDLE:   if (req_done) state <= ST_SECOND;
        ST_SECOND: if (ack_ready) state <= ST_DRAIN;
        ST_DRAIN:  if (fromhost_valid && fromhost_accept) state <= ST_IDLE;
        default:   state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && req_done)
      len_q <= req.len_words;
  end

  // holds each word until the host accepts it
  stream_slice #(
    .payload_t (dma_word_t)
  ) u_ack_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (ack_word),
    .in_valid  (ack_valid),
    .in_ready  (ack_ready),
    .out_data  (fromhost),
    .out_valid (fromhost_valid),
    .out_ready (fromhost_accept)
  );

endmodule

//--- logic/dma_up_bridge.sv
// DMA upstream bridge top level
`timescale 1ns/10ps

module dma_up_bridge (
  input  logic                 clk,
  input  logic                 rst_n,

  // host to bridge
  input  dma_pkg::dma_word_t   tohost,
  input  logic                 tohost_valid,
  output logic                 tohost_almost_full,

  // stream master
  output axis_pkg::axis_beat_t axis_out,
  output logic                 axis_tvalid,
  input  logic                 axis_tready,

  // bridge to host
  output dma_pkg::dma_word_t   fromhost,
  output logic                 fromhost_valid,
  input  logic                 fromhost_accept
);

  import dma_pkg::*;
  import axis_pkg::*;

  axis_beat_t beat;
  logic       beat_valid;
  logic       beat_ready;
  up_req_t    req;
  logic       req_done;
  logic       ack_idle;

  //**********************************************************
  // input side
  //**********************************************************
  up_req_decode u_decode (
    .clk                (clk),
    .rst_n              (rst_n),
    .tohost             (tohost),
    .tohost_valid       (tohost_valid),
    .tohost_almost_full (tohost_almost_full),
    .beat               (beat),
    .beat_valid         (beat_valid),
    .beat_ready         (beat_ready),
    .req                (req),
    .req_done           (req_done),
    .ack_idle           (ack_idle)
  );

  // payload register stage
  stream_slice #(
    .payload_t (axis_beat_t)
  ) u_beat_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (beat),
    .in_valid  (beat_valid),
    .in_ready  (beat_ready),
    .out_data  (axis_out),
    .out_valid (axis_tvalid),
    .out_ready (axis_tready)
  );

  //**********************************************************
  // acknowledge side
  //**********************************************************
  up_ack_gen u_ack (
    .clk             (clk),
    .rst_n           (rst_n),
    .req             (req),
    .req_done        (req_done),
    .ack_idle        (ack_idle),
    .fromhost        (fromhost),
    .fromhost_valid  (fromhost_valid),
    .fromhost_accept (fromhost_accept)
  );

endmodule

//--- bench/tb_clkgen.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  // ten cycles of reset, released just after an edge
  initial
  begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #2 rst_n = 1'b1;
  end

endmodule

//--- bench/dma_up_bridge_chk.sv
// Bridge handshake assertions
`timescale 1ns/10ps

module dma_up_bridge_chk (
  input logic                 clk,
  input logic                 rst_n,
  input axis_pkg::axis_beat_t axis_out,
  input logic                 axis_tvalid,
  input logic                 axis_tready,
  input dma_pkg::dma_word_t   fromhost,
  input logic                 fromhost_valid,
  input logic                 fromhost_accept
);

  // stalled beat stays put
  axis_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axis_tvalid && !axis_tready |=> axis_tvalid && $stable(axis_out))
    else $error("axis beat changed or dropped while stalled");

  // ack word waits for the host
  ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    fromhost_valid && !fromhost_accept |=> fromhost_valid && $stable(fromhost))
    else $error("ack word changed or dropped while not accepted");

  quiet_in_reset: assert property (@(posedge clk)
    !rst_n |-> !axis_tvalid && !fromhost_valid)
    else $error("valid output high during reset");

endmodule

//--- bench/dma_up_bridge_tb.sv
// Upstream bridge testbench
`timescale 1ns/10ps

module dma_up_bridge_tb;

  import dma_pkg::*;
  import axis_pkg::*;

  localparam int NUM_XFERS = 40;
  localparam int LIMIT     = 400; // cycles allowed for any one wait

  logic       clk;
  logic       rst_n;
  dma_word_t  tohost;
  logic       tohost_valid;
  logic       tohost_almost_full;
  axis_beat_t axis_out;
  logic       axis_tvalid;
  logic       axis_tready;
  dma_word_t  fromhost;
  logic       fromhost_valid;
  logic       fromhost_accept;

  logic [15:0] lfsr = 16'd62;
  dma_word_t   words_q[$];  // host words in send order
  axis_beat_t  beats_q[$];  // expected stream beats
  dma_word_t   acks_q[$];   // expected ack words
  int          beats_exp = 0;
  int          beats_seen = 0;
  int          acks_seen = 0;
  int          mismatches = 0;
  int          failures = 0;
  logic        af_hold = 1'b0;
  logic        af_reset_seen = 1'b0;

  tb_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  dma_up_bridge UUT (
    .clk                (clk),
    .rst_n              (rst_n),
    .tohost             (tohost),
    .tohost_valid       (tohost_valid),
    .tohost_almost_full (tohost_almost_full),
    .axis_out           (axis_out),
    .axis_tvalid        (axis_tvalid),
    .axis_tready        (axis_tready),
    .fromhost           (fromhost),
    .fromhost_valid     (fromhost_valid),
    .fromhost_accept    (fromhost_accept)
  );

  bind dma_up_bridge dma_up_bridge_chk u_chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .axis_out        (axis_out),
    .axis_tvalid     (axis_tvalid),
    .axis_tready     (axis_tready),
    .fromhost        (fromhost),
    .fromhost_valid  (fromhost_valid),
    .fromhost_accept (fromhost_accept)
  );

  //**********************************************************
  // random source and reference model
  //**********************************************************
  // taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[62:0], lfsr_bit()};
    return v;
  endfunction

  // low three byte count bits pick the lanes of the last word
  function automatic logic [KEEP_W-1:0] expected_keep(input logic [15:0] bytes, input logic last);
    logic [KEEP_W-1:0] k;
    int                n;
    k = '1;
    n = int'(bytes[2:0]);
    if (last && n != 0)
    begin
      k = '0;
      for (int i = 0; i < n; i++)
        k[i] = 1'b1;
    end
    return k;
  endfunction

  task automatic build_transfers();
    dma_word_t   w;
    axis_beat_t  b;
    logic [31:0] tag;
    logic [15:0] bytes;
    int          n;
    for (int t = 0; t < NUM_XFERS; t++)
    begin
      tag   = 32'(rand_bits(32));
      n     = int'(rand_bits(3)) + 1;
      bytes = 16'(rand_bits(16));
      w.ctrl = '0;
      w.ctrl[CTRL_REQ] = 1'b1;
      w.data = {tag, 16'(rand_bits(16)), 16'(n)}; // middle bits are don't care
      words_q.push_back(w);
      w.data = {bytes, 48'(rand_bits(48))};
      words_q.push_back(w);
      for (int i = 0; i < n; i++)
      begin
        w.ctrl = '0;
        w.ctrl[CTRL_END] = (i == n - 1);
        w.data = rand_bits(64);
        words_q.push_back(w);
        b.tdata = w.data;
        b.tlast = (i == n - 1);
        b.tkeep = expected_keep(bytes, b.tlast);
        beats_q.push_back(b);
        beats_exp++;
      end
      // first ack carries tag bits 7..4 in place
      w = '0;
      w.ctrl[CTRL_FIRST_ACK] = 1'b1;
      w.ctrl[CTRL_REQ]       = 1'b1;
      w.data[7:4]            = tag[7:4];
      acks_q.push_back(w);
      w = '0;
      w.ctrl[CTRL_REQ]        = 1'b1;
      w.ctrl[CTRL_SECOND_ACK] = 1'b1;
      w.data[23:0]            = 24'(n);
      acks_q.push_back(w);
    end
  endtask

  //**********************************************************
  // driver and monitor
  //**********************************************************
  task automatic send_word(input dma_word_t w);
    int waited;
    waited       = 0;
    tohost       = w;
    tohost_valid = 1'b1;
    @(negedge clk);
    while (tohost_almost_full && waited < LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (waited >= LIMIT)
    begin
      $display("error at %0t: host word never accepted by the bridge", $time);
      failures++;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic check_cycle();
    axis_beat_t eb;
    dma_word_t  ea;
    if (af_hold && !tohost_almost_full)
    begin
      $display("error at %0t: almost_full low before the second ack was taken", $time);
      failures++;
    end
    if (tohost_valid && !tohost_almost_full && tohost.ctrl[CTRL_END])
      af_hold = 1'b1; // end word taken at the coming edge
    if (axis_tvalid && axis_tready)
    begin
      beats_seen++;
      if (beats_q.size() == 0)
      begin
        $display("error at %0t: stream beat with none expected", $time);
        failures++;
      end
      else
      begin
        eb = beats_q.pop_front();
        if (axis_out !== eb)
        begin
          $display("mismatch at %0t: beat %h/%h/%b expected %h/%h/%b", $time, axis_out.tdata,
                   axis_out.tkeep, axis_out.tlast, eb.tdata, eb.tkeep, eb.tlast);
          mismatches++;
        end
      end
    end
    if (fromhost_valid && fromhost_accept)
    begin
      acks_seen++;
      if (acks_q.size() == 0)
      begin
        $display("error at %0t: ack word with none expected", $time);
        failures++;
      end
      else
      begin
        ea = acks_q.pop_front();
        if (fromhost !== ea)
        begin
          $display("mismatch at %0t: ack %h/%h expected %h/%h", $time,
                   fromhost.data, fromhost.ctrl, ea.data, ea.ctrl);
          mismatches++;
        end
        if (ea.ctrl[CTRL_SECOND_ACK])
          af_hold = 1'b0;
      end
    end
  endtask

  // sink side with random ready and accept every cycle
  initial
  begin
    int waited;
    axis_tready     = 1'b0;
    fromhost_accept = 1'b0;
    waited          = 0;
    while (rst_n !== 1'b1 && waited < LIMIT)
    begin
      @(negedge clk);
      if (rst_n === 1'b0 && tohost_almost_full)
        af_reset_seen = 1'b1;
      waited++;
    end
    forever
    begin
      @(posedge clk);
      #2;
      axis_tready     = lfsr_bit();
      fromhost_accept = lfsr_bit();
      @(negedge clk);
      check_cycle();
    end
  end

  //**********************************************************
  // main sequence
  //**********************************************************
  initial
  begin
    int waited;
    tohost       = '0;
    tohost_valid = 1'b0;
    build_transfers();
    waited = 0;
    while (rst_n !== 1'b1 && waited < LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (waited >= LIMIT)
    begin
      $display("error: reset was never released");
      failures++;
    end
    @(posedge clk);
    #2;
    foreach (words_q[i])
      send_word(words_q[i]);
    tohost_valid = 1'b0;
    waited = 0;
    while ((beats_q.size() != 0 || acks_q.size() != 0) && waited < LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    if (waited >= LIMIT)
    begin
      $display("error: %0d beats and %0d acks never arrived", beats_q.size(), acks_q.size());
      failures++;
    end
    repeat (10) @(posedge clk); // room for stray extra words
    if (beats_seen != beats_exp || acks_seen != 2 * NUM_XFERS)
    begin
      $display("mismatch at %0t: totals differ from the model", $time);
      mismatches++;
    end
    if (!af_reset_seen)
    begin
      $display("error: almost_full was not high during reset");
      failures++;
    end
    $display("beats %0d of %0d, acks %0d of %0d, mismatches %0d, other errors %0d",
             beats_seen, beats_exp, acks_seen, 2 * NUM_XFERS, mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- filelist.f
logic/dma_pkg.sv
logic/axis_pkg.sv
logic/stream_slice.sv
logic/up_req_decode.sv
logic/up_ack_gen.sv
logic/dma_up_bridge.sv
bench/tb_clkgen.sv
bench/dma_up_bridge_chk.sv
bench/dma_up_bridge_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module dma_up_bridge_tb \
  -f filelist.f \
  -o sim_dma_up_bridge
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_dma_up_bridge)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
  exit 0
fi
echo "pass message not found"
exit 1
